// ==== src.f ====
source/lc4_pkg.sv
source/lc4_regfile.sv
source/lc4_decode.sv
source/lc4_execute.sv
source/lc4_result.sv
source/lc4_pipeline.sv
sim/lc4_props.sv
sim/lc4_tb.sv

// ==== Bender.yml ====
package:
  name: lc4_pipeline

sources:
  - files:
      - source/lc4_pkg.sv
      - source/lc4_regfile.sv
      - source/lc4_decode.sv
      - source/lc4_execute.sv
      - source/lc4_result.sv
      - source/lc4_pipeline.sv
  - target: simulation
    files:
      - sim/lc4_props.sv
      - sim/lc4_tb.sv

// ==== sim/lc4_tb.sv ====
// Testbench for lc4_pipeline; only forward branches, the program must fit in NROWS words from RESET_PC
module lc4_tb;

    localparam int             PERIOD   = 8;
    localparam int             NROWS    = 66;
    localparam lc4_pkg::word_t RESET_PC = 16'h8200;
    // Generous bound on the run, three cycles per row plus reset and drain
    localparam int             TIMEOUT  = (NROWS * 3 + 20) * PERIOD;

    // One program word with the retire flag and what its trace must show
    typedef struct packed {
        lc4_pkg::word_t    insn;
        logic              retire;
        logic              we;
        lc4_pkg::reg_sel_t wsel;
        lc4_pkg::word_t    wdata;
        logic              nzp_we;
        lc4_pkg::nzp_t     nzp;
        logic              dmem_we;
        lc4_pkg::word_t    dmem_addr;
        lc4_pkg::word_t    dmem_wdata;
    } row_t;

    logic            gwe;
    logic            arst_n;
    lc4_pkg::word_t  cur_insn;
    lc4_pkg::word_t  dmem_rdata;
    lc4_pkg::word_t  cur_pc;
    lc4_pkg::word_t  dmem_addr;
    logic            dmem_we;
    lc4_pkg::word_t  dmem_towrite;
    lc4_pkg::trace_t trace;

    row_t            rows [NROWS];
    // Data memory seen by the DUT, and the model's own copy
    lc4_pkg::word_t  dmem [65536];
    lc4_pkg::word_t  mmem [65536];
    // Cycle in which each program pc was last on o_cur_pc
    int              pc_seen [NROWS];
    int              cycle;
    int              checks;
    int              errors;
    integer          seed = 32'hfabf;

    lc4_pipeline #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .gwe             (gwe),
        .i_arst_n        (arst_n),
        .i_cur_insn      (cur_insn),
        .i_cur_dmem_data (dmem_rdata),
        .o_cur_pc        (cur_pc),
        .o_dmem_addr     (dmem_addr),
        .o_dmem_we       (dmem_we),
        .o_dmem_towrite  (dmem_towrite),
        .o_trace         (trace)
    );

    initial begin
        gwe = 1'b0;
        forever begin
            #(PERIOD / 2) gwe = ~gwe;
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Timeout: the core stopped retiring before the end of the program");
        $display("TEST FAILED");
        $finish;
    end

    function automatic lc4_pkg::word_t fill_word(input lc4_pkg::word_t addr);
        fill_word = {addr[7:0], addr[15:8]} ^ 16'h3c5a;
    endfunction

    function automatic lc4_pkg::word_t sext(input lc4_pkg::word_t v, input int bits);
        sext = v[bits-1] ? (v | (16'hffff << bits)) : (v & ~(16'hffff << bits));
    endfunction

    function automatic lc4_pkg::nzp_t nzp_of(input lc4_pkg::word_t v);
        nzp_of = (v == '0) ? 3'b010 : (v[15] ? 3'b100 : 3'b001);
    endfunction

    // Register form, d s sub t
    function automatic lc4_pkg::word_t rtype(input logic [3:0] op, input logic [2:0] d,
                                             input logic [2:0] s, input logic [2:0] sub,
                                             input logic [2:0] t);
        rtype = {op, d, s, sub, t};
    endfunction

    // Low nine bits given whole, d doubles as nzp for BR and as rt for STR
    function automatic lc4_pkg::word_t itype(input logic [3:0] op, input logic [2:0] d,
                                             input logic [8:0] low);
        itype = {op, d, low};
    endfunction

    function automatic int next_retiring(input int from);
        int i;
        i = from;
        while (i < NROWS && !rows[i].retire) begin
            i = i + 1;
        end
        next_retiring = i;
    endfunction

    task automatic expect_eq(input string name, input lc4_pkg::word_t exp,
                             input lc4_pkg::word_t act);
        checks = checks + 1;
        if (act !== exp) begin
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        int          k;
        for (k = 0; k < NROWS; k++) begin
            rows[k] = '0;
        end
        // Dependent arithmetic and logic chain
        rows[0].insn  = itype(lc4_pkg::OP_CONST, 3'd1, 9'd5);
        rows[1].insn  = itype(lc4_pkg::OP_CONST, 3'd2, 9'h1fd);
        rows[2].insn  = rtype(lc4_pkg::OP_ARITH, 3'd3, 3'd1, 3'b000, 3'd2);
        rows[3].insn  = rtype(lc4_pkg::OP_ARITH, 3'd4, 3'd3, 3'b010, 3'd1);
        rows[4].insn  = itype(lc4_pkg::OP_ARITH, 3'd4, {3'd4, 1'b1, 5'b11001});
        rows[5].insn  = rtype(lc4_pkg::OP_LOGIC, 3'd5, 3'd4, 3'b000, 3'd2);
        rows[6].insn  = rtype(lc4_pkg::OP_LOGIC, 3'd6, 3'd5, 3'b010, 3'd1);
        rows[7].insn  = rtype(lc4_pkg::OP_LOGIC, 3'd7, 3'd6, 3'b011, 3'd4);
        rows[8].insn  = rtype(lc4_pkg::OP_LOGIC, 3'd1, 3'd7, 3'b011, 3'd7);
        // Store, load back, use at once, then a load from the fill pattern
        rows[9].insn  = itype(lc4_pkg::OP_CONST, 3'd2, 9'h040);
        rows[10].insn = itype(lc4_pkg::OP_STR, 3'd7, {3'd2, 6'd3});
        rows[11].insn = itype(lc4_pkg::OP_LDR, 3'd3, {3'd2, 6'd3});
        rows[12].insn = rtype(lc4_pkg::OP_ARITH, 3'd4, 3'd3, 3'b000, 3'd3);
        rows[13].insn = itype(lc4_pkg::OP_LDR, 3'd5, {3'd2, 6'h3e});
        // Taken BRn over two slots, a not-taken BRzp, NOP, then BRz right after its flag setter
        rows[14].insn = itype(lc4_pkg::OP_ARITH, 3'd6, {3'd1, 1'b1, 5'h1f});
        rows[15].insn = itype(lc4_pkg::OP_BR, 3'b100, 9'd2);
        rows[16].insn = itype(lc4_pkg::OP_CONST, 3'd7, 9'd1);
        rows[17].insn = rtype(lc4_pkg::OP_ARITH, 3'd7, 3'd7, 3'b000, 3'd7);
        rows[18].insn = itype(lc4_pkg::OP_BR, 3'b011, 9'd1);
        rows[19].insn = lc4_pkg::NOP_INSN;
        rows[20].insn = itype(lc4_pkg::OP_CONST, 3'd0, 9'd0);
        rows[21].insn = itype(lc4_pkg::OP_BR, 3'b010, 9'd3);
        rows[22].insn = itype(lc4_pkg::OP_CONST, 3'd1, 9'd7);
        rows[23].insn = itype(lc4_pkg::OP_CONST, 3'd1, 9'd8);
        rows[24].insn = itype(lc4_pkg::OP_CONST, 3'd1, 9'd9);
        rows[25].insn = rtype(lc4_pkg::OP_ARITH, 3'd2, 3'd0, 3'b000, 3'd6);
        // Random CONST and operation pairs, r2 accumulates
        for (k = 0; k < 20; k++) begin
            rnd = $random(seed);
            rows[26 + 2 * k].insn = itype(lc4_pkg::OP_CONST, 3'd1, rnd[8:0]);
            case (k % 6)
                0: rows[27 + 2 * k].insn = rtype(lc4_pkg::OP_ARITH, 3'd2, 3'd1, 3'b000, 3'd2);
                1: rows[27 + 2 * k].insn = rtype(lc4_pkg::OP_ARITH, 3'd2, 3'd1, 3'b010, 3'd2);
                2: rows[27 + 2 * k].insn = itype(lc4_pkg::OP_ARITH, 3'd2,
                                                 {3'd1, 1'b1, rnd[13:9]});
                3: rows[27 + 2 * k].insn = rtype(lc4_pkg::OP_LOGIC, 3'd2, 3'd1, 3'b000, 3'd2);
                4: rows[27 + 2 * k].insn = rtype(lc4_pkg::OP_LOGIC, 3'd2, 3'd1, 3'b010, 3'd2);
                default: rows[27 + 2 * k].insn = rtype(lc4_pkg::OP_LOGIC, 3'd2, 3'd1,
                                                       3'b011, 3'd2);
            endcase
        end
    endtask

    // Sequential ISA model, fills in retire flags and expected trace fields
    task automatic run_model();
        lc4_pkg::word_t r [8];
        lc4_pkg::nzp_t  cc;
        lc4_pkg::word_t insn;
        lc4_pkg::word_t rs;
        lc4_pkg::word_t rt;
        lc4_pkg::word_t ea;
        lc4_pkg::word_t v;
        int             i;
        int             nxt;
        r  = '{default: '0};
        cc = '0;
        i  = 0;
        while (i < NROWS) begin
            insn = rows[i].insn;
            rs   = r[insn[8:6]];
            rt   = r[insn[2:0]];
            ea   = rs + sext(insn, 6);
            v    = '0;
            nxt  = i + 1;
            rows[i].retire = 1'b1;
            rows[i].wsel   = insn[11:9];
            case (insn[15:12])
                lc4_pkg::OP_ARITH: begin
                    rows[i].we = 1'b1;
                    v = insn[5] ? rs + sext(insn, 5) : (insn[4:3] == 2'b10 ? rs - rt : rs + rt);
                end
                lc4_pkg::OP_LOGIC: begin
                    rows[i].we = 1'b1;
                    v = (insn[5:3] == 3'b000) ? (rs & rt) :
                        ((insn[5:3] == 3'b010) ? (rs | rt) : (rs ^ rt));
                end
                lc4_pkg::OP_CONST: begin
                    rows[i].we = 1'b1;
                    v = sext(insn, 9);
                end
                lc4_pkg::OP_LDR: begin
                    rows[i].we        = 1'b1;
                    rows[i].dmem_addr = ea;
                    v = mmem[ea];
                end
                lc4_pkg::OP_STR: begin
                    rows[i].dmem_we    = 1'b1;
                    rows[i].dmem_addr  = ea;
                    rows[i].dmem_wdata = r[insn[11:9]];
                    mmem[ea] = r[insn[11:9]];
                end
                default: begin
                    // BR, the all-zero NOP never matches
                    if (|(insn[11:9] & cc)) begin
                        nxt = i + 1 + int'($signed(sext(insn, 9)));
                    end
                end
            endcase
            // Every register write also sets the flags
            if (rows[i].we) begin
                r[insn[11:9]]  = v;
                cc             = nzp_of(v);
                rows[i].nzp_we = 1'b1;
                rows[i].wdata  = v;
                rows[i].nzp    = cc;
            end
            i = nxt;
        end
    endtask

    // One cycle: falling edge drives both memories, checks follow a quarter period later
    task automatic step(input logic rst_n);
        lc4_pkg::word_t off;
        @(negedge gwe);
        cycle  = cycle + 1;
        arst_n = rst_n;
        if (dmem_we) begin
            dmem[dmem_addr] = dmem_towrite;
        end
        dmem_rdata = dmem[dmem_addr];
        off = cur_pc - RESET_PC;
        if (off < NROWS) begin
            cur_insn     = rows[off].insn;
            pc_seen[off] = cycle;
        end else begin
            cur_insn = lc4_pkg::NOP_INSN;
        end
        #(PERIOD / 4);
    endtask

    task automatic verify_reset();
        expect_eq("o_cur_pc", RESET_PC, cur_pc);
        expect_eq("o_trace.valid", 16'd0, trace.valid);
        expect_eq("o_dmem_we", 16'd0, dmem_we);
    endtask

    task automatic verify_retired(input int idx);
        row_t r;
        r = rows[idx];
        expect_eq("o_trace.pc", RESET_PC + lc4_pkg::word_t'(idx), trace.pc);
        expect_eq("o_trace.insn", r.insn, trace.insn);
        // Three rising edges from o_cur_pc to the trace
        expect_eq("trace latency", 16'd3, lc4_pkg::word_t'(cycle - pc_seen[idx]));
        expect_eq("o_trace.regfile_we", r.we, trace.regfile_we);
        expect_eq("o_trace.nzp_we", r.nzp_we, trace.nzp_we);
        if (r.we) begin
            expect_eq("o_trace.wsel", r.wsel, trace.wsel);
            expect_eq("o_trace.wdata", r.wdata, trace.wdata);
        end
        if (r.nzp_we) begin
            expect_eq("o_trace.nzp", r.nzp, trace.nzp);
        end
        expect_eq("o_dmem_we", r.dmem_we, dmem_we);
        expect_eq("o_dmem_addr", r.dmem_addr, dmem_addr);
        if (r.dmem_we) begin
            expect_eq("o_dmem_towrite", r.dmem_wdata, dmem_towrite);
        end
    endtask

    initial begin
        int a;
        int row;
        arst_n     = 1'b0;
        cur_insn   = lc4_pkg::NOP_INSN;
        dmem_rdata = '0;
        cycle      = 0;
        checks     = 0;
        errors     = 0;
        for (a = 0; a < 65536; a++) begin
            dmem[a] = fill_word(a[15:0]);
            mmem[a] = dmem[a];
        end
        build_program();
        run_model();
        // Two cycles in reset, checked inside and just after
        step(1'b0);
        verify_reset();
        step(1'b1);
        verify_reset();
        // Each valid trace consumes the next row that should retire
        row = next_retiring(0);
        while (row < NROWS) begin
            step(1'b1);
            if (trace.valid) begin
                verify_retired(row);
                row = next_retiring(row + 1);
            end
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/lc4_props.sv ====
// Assertions for lc4_pipeline; the redirect check assumes no stall, so flushed slots reach result 2 and 3 edges later
module lc4_props (
    input logic               gwe,
    input logic               i_arst_n,
    input logic               i_dmem_we,
    input lc4_pkg::trace_t    i_trace,
    input lc4_pkg::redirect_t i_redirect
);

    // A memory write comes only from a live STR, which never writes a register
    property store_from_valid_slot;
        @(posedge gwe) disable iff (!i_arst_n)
        i_dmem_we |-> (i_trace.valid && (i_trace.insn[15:12] == lc4_pkg::OP_STR)
                       && !i_trace.regfile_we);
    endproperty

    // Falling edge, so the first reset edge has already been applied
    property no_store_in_reset;
        @(negedge gwe)
        !i_arst_n |-> !i_dmem_we;
    endproperty

    // Both younger slots must reach result as bubbles
    property flushed_slots_stay_dead;
        @(posedge gwe) disable iff (!i_arst_n)
        i_redirect.taken |-> ##2 !i_trace.valid ##1 !i_trace.valid;
    endproperty

    assert property (store_from_valid_slot)
        else $error("Data memory write without a valid STR in result");
    assert property (no_store_in_reset)
        else $error("Data memory write while reset is asserted");
    assert property (flushed_slots_stay_dead)
        else $error("Slot fetched behind a taken branch retired as valid");

endmodule

bind lc4_pipeline lc4_props u_props (
    .gwe        (gwe),
    .i_arst_n   (i_arst_n),
    .i_dmem_we  (o_dmem_we),
    .i_trace    (o_trace),
    .i_redirect (redirect)
);

// ==== source/lc4_pipeline.sv ====
// Three-stage LC4 core top; both memories sit outside and answer combinationally
module lc4_pipeline #(
    parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic            gwe,
    input  logic            i_arst_n,
    input  lc4_pkg::word_t  i_cur_insn,
    input  lc4_pkg::word_t  i_cur_dmem_data,
    output lc4_pkg::word_t  o_cur_pc,
    output lc4_pkg::word_t  o_dmem_addr,
    output logic            o_dmem_we,
    output lc4_pkg::word_t  o_dmem_towrite,
    output lc4_pkg::trace_t o_trace
);

    lc4_pkg::dec_t      dec;
    lc4_pkg::exe_t      exe;
    lc4_pkg::redirect_t redirect;
    lc4_pkg::wb_t       wb;
    lc4_pkg::nzp_t      nzp;

    lc4_decode #(
        .RESET_PC (RESET_PC)
    ) u_decode (
        .gwe        (gwe),
        .i_arst_n   (i_arst_n),
        .i_cur_insn (i_cur_insn),
        .i_redirect (redirect),
        .i_wb       (wb),
        .o_cur_pc   (o_cur_pc),
        .o_dec      (dec)
    );

    lc4_execute u_execute (
        .gwe        (gwe),
        .i_arst_n   (i_arst_n),
        .i_dec      (dec),
        .i_wb       (wb),
        .i_nzp      (nzp),
        .o_exe      (exe),
        .o_redirect (redirect)
    );

    // Also feeds the register file and the execute bypass
    lc4_result u_result (
        .gwe             (gwe),
        .i_arst_n        (i_arst_n),
        .i_exe           (exe),
        .i_cur_dmem_data (i_cur_dmem_data),
        .o_dmem_addr     (o_dmem_addr),
        .o_dmem_towrite  (o_dmem_towrite),
        .o_dmem_we       (o_dmem_we),
        .o_wb            (wb),
        .o_nzp           (nzp),
        .o_trace         (o_trace)
    );

endmodule

// ==== source/lc4_result.sv ====
// Result stage; data memory must return i_cur_dmem_data in the same cycle as o_dmem_addr
module lc4_result (
    input  logic              gwe,
    input  logic              i_arst_n,
    input  lc4_pkg::exe_t     i_exe,
    input  lc4_pkg::word_t    i_cur_dmem_data,
    output lc4_pkg::word_t    o_dmem_addr,
    output lc4_pkg::word_t    o_dmem_towrite,
    output logic              o_dmem_we,
    output lc4_pkg::wb_t      o_wb,
    output lc4_pkg::nzp_t     o_nzp,
    output lc4_pkg::trace_t   o_trace
);

    logic           valid_q;
    lc4_pkg::exe_t  q;
    lc4_pkg::word_t wdata;
    lc4_pkg::nzp_t  nzp_new;
    lc4_pkg::nzp_t  nzp_q;
    logic           nzp_upd;

    // Slot valid
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_exe.valid;
        end
    end

    always_ff @(posedge gwe) begin
        q <= i_exe;
    end

    // Memory port only talks for valid loads and stores
    assign o_dmem_addr    = (valid_q && (q.ctrl.is_load || q.ctrl.is_store)) ? q.alu_result : '0;
    assign o_dmem_we      = valid_q && q.ctrl.is_store;
    assign o_dmem_towrite = o_dmem_we ? q.store_data : '0;

    assign wdata   = q.ctrl.is_load ? i_cur_dmem_data : q.alu_result;
    assign nzp_new = (wdata == '0) ? 3'b010 : (wdata[15] ? 3'b100 : 3'b001);
    assign nzp_upd = valid_q && q.ctrl.nzp_we;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            nzp_q <= '0;
        end else if (nzp_upd) begin
            nzp_q <= nzp_new;
        end
    end

    // Bypass so a branch right behind a flag setter sees the new flags
    assign o_nzp = nzp_upd ? nzp_new : nzp_q;

    always_comb begin
        o_wb.we    = valid_q && q.ctrl.regfile_we;
        o_wb.wsel  = q.wsel;
        o_wb.wdata = wdata;
    end

    always_comb begin
        o_trace.valid      = valid_q;
        o_trace.pc         = q.pc;
        o_trace.insn       = q.insn;
        o_trace.regfile_we = q.ctrl.regfile_we;
        o_trace.wsel       = q.wsel;
        o_trace.wdata      = wdata;
        o_trace.nzp_we     = q.ctrl.nzp_we;
        o_trace.nzp        = nzp_new;
    end

endmodule

// ==== source/lc4_execute.sv ====
// Execute stage with forwarding from the result stage only; branches resolve here against i_nzp
module lc4_execute (
    input  logic                gwe,
    input  logic                i_arst_n,
    input  lc4_pkg::dec_t       i_dec,
    input  lc4_pkg::wb_t        i_wb,
    input  lc4_pkg::nzp_t       i_nzp,
    output lc4_pkg::exe_t       o_exe,
    output lc4_pkg::redirect_t  o_redirect
);

    logic           valid_q;
    lc4_pkg::dec_t  q;
    lc4_pkg::word_t rs_fwd;
    lc4_pkg::word_t rt_fwd;
    lc4_pkg::word_t op_b;
    lc4_pkg::word_t alu_result;
    logic           br_taken;

    // Slot valid
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_dec.valid;
        end
    end

    // Payload, q.valid is shadowed by valid_q
    always_ff @(posedge gwe) begin
        q <= i_dec;
    end

    // Older writes already went through the register file write-through
    always_comb begin
        if (i_wb.we && (i_wb.wsel == q.rs_sel)) begin
            rs_fwd = i_wb.wdata;
        end else begin
            rs_fwd = q.rs_data;
        end
        if (i_wb.we && (i_wb.wsel == q.rt_sel)) begin
            rt_fwd = i_wb.wdata;
        end else begin
            rt_fwd = q.rt_data;
        end
    end

    assign op_b = q.ctrl.use_imm ? q.imm : rt_fwd;

    // LDR and STR use ADD with the offset to form the address
    always_comb begin
        case (q.ctrl.alu_op)
            lc4_pkg::ALU_ADD:      alu_result = rs_fwd + op_b;
            lc4_pkg::ALU_SUB:      alu_result = rs_fwd - op_b;
            lc4_pkg::ALU_AND:      alu_result = rs_fwd & op_b;
            lc4_pkg::ALU_OR:       alu_result = rs_fwd | op_b;
            lc4_pkg::ALU_XOR:      alu_result = rs_fwd ^ op_b;
            lc4_pkg::ALU_PASS_IMM: alu_result = q.imm;
            default:               alu_result = '0;
        endcase
    end

    // Condition bits n, z, p in insn[11:9] line up with nzp_t
    assign br_taken = valid_q && q.ctrl.is_branch && (|(q.insn[11:9] & i_nzp));

    always_comb begin
        o_redirect.taken  = br_taken;
        o_redirect.target = q.pc + 16'd1 + q.imm;
    end

    // The branch itself still retires
    always_comb begin
        o_exe.valid      = valid_q;
        o_exe.pc         = q.pc;
        o_exe.insn       = q.insn;
        o_exe.ctrl       = q.ctrl;
        o_exe.alu_result = alu_result;
        o_exe.store_data = rt_fwd;
        o_exe.wsel       = q.wsel;
    end

endmodule

// ==== source/lc4_decode.sv ====
// PC, fetch register and decoder; instruction memory must answer i_cur_insn in the same cycle
module lc4_decode #(
    parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic                gwe,
    input  logic                i_arst_n,
    input  lc4_pkg::word_t      i_cur_insn,
    input  lc4_pkg::redirect_t  i_redirect,
    input  lc4_pkg::wb_t        i_wb,
    output lc4_pkg::word_t      o_cur_pc,
    output lc4_pkg::dec_t       o_dec
);

    lc4_pkg::word_t    pc_q;
    logic              fetch_valid;
    lc4_pkg::word_t    fetch_pc;
    lc4_pkg::word_t    fetch_insn;
    lc4_pkg::opcode_t  opcode;
    lc4_pkg::ctrl_t    ctrl;
    lc4_pkg::word_t    imm;
    lc4_pkg::reg_sel_t rt_sel;
    lc4_pkg::word_t    rs_data;
    lc4_pkg::word_t    rt_data;

    // PC and fetch valid; a redirect kills the slot fetched this cycle
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q        <= RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            pc_q        <= i_redirect.taken ? i_redirect.target : pc_q + 16'd1;
            fetch_valid <= !i_redirect.taken;
        end
    end

    // Fetch payload
    always_ff @(posedge gwe) begin
        fetch_pc   <= pc_q;
        fetch_insn <= i_cur_insn;
    end

    assign o_cur_pc = pc_q;
    assign opcode   = lc4_pkg::opcode_t'(fetch_insn[15:12]);

    always_comb begin
        ctrl   = '0;
        imm    = '0;
        rt_sel = fetch_insn[2:0];
        case (opcode)
            lc4_pkg::OP_BR: begin
                ctrl.is_branch = 1'b1;
                imm            = {{7{fetch_insn[8]}}, fetch_insn[8:0]};
            end
            lc4_pkg::OP_ARITH: begin
                ctrl.regfile_we = 1'b1;
                ctrl.nzp_we     = 1'b1;
                imm             = {{11{fetch_insn[4]}}, fetch_insn[4:0]};
                if (fetch_insn[5]) begin
                    ctrl.use_imm = 1'b1;
                    ctrl.alu_op  = lc4_pkg::ALU_ADD;
                end else if (fetch_insn[5:3] == 3'b000) begin
                    ctrl.alu_op = lc4_pkg::ALU_ADD;
                end else if (fetch_insn[5:3] == 3'b010) begin
                    ctrl.alu_op = lc4_pkg::ALU_SUB;
                end else begin
                    // MUL and DIV are not built
                    ctrl.regfile_we = 1'b0;
                    ctrl.nzp_we     = 1'b0;
                end
            end
            lc4_pkg::OP_LOGIC: begin
                ctrl.regfile_we = 1'b1;
                ctrl.nzp_we     = 1'b1;
                case (fetch_insn[5:3])
                    3'b000:  ctrl.alu_op = lc4_pkg::ALU_AND;
                    3'b010:  ctrl.alu_op = lc4_pkg::ALU_OR;
                    3'b011:  ctrl.alu_op = lc4_pkg::ALU_XOR;
                    // NOT and AND immediate fall here
                    default: begin
                        ctrl.regfile_we = 1'b0;
                        ctrl.nzp_we     = 1'b0;
                    end
                endcase
            end
            lc4_pkg::OP_LDR: begin
                ctrl.alu_op     = lc4_pkg::ALU_ADD;
                ctrl.use_imm    = 1'b1;
                ctrl.is_load    = 1'b1;
                ctrl.regfile_we = 1'b1;
                ctrl.nzp_we     = 1'b1;
                imm             = {{10{fetch_insn[5]}}, fetch_insn[5:0]};
            end
            lc4_pkg::OP_STR: begin
                ctrl.alu_op   = lc4_pkg::ALU_ADD;
                ctrl.use_imm  = 1'b1;
                ctrl.is_store = 1'b1;
                imm           = {{10{fetch_insn[5]}}, fetch_insn[5:0]};
                // Store data sits in the destination field
                rt_sel        = fetch_insn[11:9];
            end
            lc4_pkg::OP_CONST: begin
                ctrl.alu_op     = lc4_pkg::ALU_PASS_IMM;
                ctrl.regfile_we = 1'b1;
                ctrl.nzp_we     = 1'b1;
                imm             = {{7{fetch_insn[8]}}, fetch_insn[8:0]};
            end
            default: ;
        endcase
    end

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs_sel  (fetch_insn[8:6]),
        .i_rt_sel  (rt_sel),
        .i_wb      (i_wb),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    // Second flushed slot is the one now in decode
    always_comb begin
        o_dec.valid   = fetch_valid && !i_redirect.taken;
        o_dec.pc      = fetch_pc;
        o_dec.insn    = fetch_insn;
        o_dec.ctrl    = ctrl;
        o_dec.rs_sel  = fetch_insn[8:6];
        o_dec.rt_sel  = rt_sel;
        o_dec.rs_data = rs_data;
        o_dec.rt_data = rt_data;
        o_dec.imm     = imm;
        o_dec.wsel    = fetch_insn[11:9];
    end

endmodule

// ==== source/lc4_regfile.sv ====
// Eight registers cleared by reset; a read of the register being written returns the new data
module lc4_regfile (
    input  logic              gwe,
    input  logic              i_arst_n,
    input  lc4_pkg::reg_sel_t i_rs_sel,
    input  lc4_pkg::reg_sel_t i_rt_sel,
    input  lc4_pkg::wb_t      i_wb,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data
);

    lc4_pkg::word_t regs [8];

    // Architectural state, so it is cleared on reset
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            regs <= '{default: '0};
        end else if (i_wb.we) begin
            regs[i_wb.wsel] <= i_wb.wdata;
        end
    end

    // Write-through covers the result stage writing what decode reads
    always_comb begin
        if (i_wb.we && (i_wb.wsel == i_rs_sel)) begin
            o_rs_data = i_wb.wdata;
        end else begin
            o_rs_data = regs[i_rs_sel];
        end
        if (i_wb.we && (i_wb.wsel == i_rt_sel)) begin
            o_rt_data = i_wb.wdata;
        end else begin
            o_rt_data = regs[i_rt_sel];
        end
    end

endmodule

// ==== source/lc4_pkg.sv ====
// Shared LC4 types; only BR, ADD, SUB, AND, OR, XOR, CONST, LDR and STR exist, all other encodings decode as no-ops
package lc4_pkg;

    // Data and address width
    localparam int XLEN = 16;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [2:0]      reg_sel_t;
    // N in bit 2, Z in bit 1, P in bit 0
    typedef logic [2:0]      nzp_t;

    // BR with no condition bits set, so never taken
    localparam word_t NOP_INSN = '0;

    // Top nibble of the instruction
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_IMM
    } alu_op_t;

    // Decoded controls, carried down to the result stage
    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    regfile_we;
        logic    nzp_we;
        logic    is_load;
        logic    is_store;
        logic    is_branch;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        ctrl_t    ctrl;
        reg_sel_t rs_sel;
        reg_sel_t rt_sel;
        word_t    rs_data;
        word_t    rt_data;
        word_t    imm;
        reg_sel_t wsel;
    } dec_t;

    // Execute to result, alu_result doubles as the memory address
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    store_data;
        reg_sel_t wsel;
    } exe_t;

    // Register write from the result stage
    typedef struct packed {
        logic     we;
        reg_sel_t wsel;
        word_t    wdata;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // One slot as it leaves the result stage
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        logic     regfile_we;
        reg_sel_t wsel;
        word_t    wdata;
        logic     nzp_we;
        nzp_t     nzp;
    } trace_t;

endpackage
